/* src.f */
+incdir+src
+incdir+testbench
src/rob_pkg.sv
src/rob_alloc.sv
src/rob_table.sv
src/rob_commit.sv
src/rob_top.sv
testbench/tb_rob.sv

/* run.sh */
#!/bin/sh
# build and run the reorder buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f src.f --top-module tb_rob -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_rob > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    exit 1
fi
exit 0

/* testbench/tb_rob_vectors.svh */
`ifndef TB_ROB_VECTORS_SVH
`define TB_ROB_VECTORS_SVH

// entry count, loads on the slb port, rdy gap mask, completion order
// order nibble j names the entry that completes j-th
task automatic set_row(int r, int n, logic loads, logic [15:0] gap, logic [63:0] order);
    row_n[r]     = n;
    row_loads[r] = loads;
    row_gap[r]   = gap;
    row_order[r] = order;
endtask

task automatic set_entry(int r, int i, kind_t kind, reg_idx_t rd, logic pred,
                         logic actual, word_t data, addr_t target);
    row_ent[r][i] = {kind, rd, pred, actual, data, target};
endtask

task automatic load_rows();
    int i;
    // four register writes, newest completes first
    set_row(0, 4, 1'b0, 16'h0000, 64'h0123);
    for (i = 0; i < 4; i++)
        set_entry(0, i, `KIND_REG, reg_idx_t'(i + 1), 1'b0, 1'b0, 32'h1111_0000 + i, '0);
    // store, correct branch, load, store
    set_row(1, 4, 1'b1, 16'h0000, 64'h2301);
    set_entry(1, 0, `KIND_STORE,  5'd0,  1'b0, 1'b0, 32'h0,         32'h0);
    set_entry(1, 1, `KIND_BRANCH, 5'd0,  1'b1, 1'b1, 32'h0,         32'h0000_0200);
    set_entry(1, 2, `KIND_REG,    5'd7,  1'b0, 1'b0, 32'hcafe_0007, 32'h0);
    set_entry(1, 3, `KIND_STORE,  5'd0,  1'b0, 1'b0, 32'h0,         32'h0);
    // fills the buffer and wraps the tags
    set_row(2, 16, 1'b0, 16'h0000, 64'hfedc_ba98_7654_3210);
    for (i = 0; i < 16; i++)
        set_entry(2, i, `KIND_REG, reg_idx_t'(i + 8), 1'b0, 1'b0, 32'h5a5a_0000 + i * 7, '0);
    // mispredict with younger entries done that never retire
    set_row(3, 5, 1'b0, 16'h0000, 64'h01234);
    set_entry(3, 0, `KIND_REG,    5'd10, 1'b0, 1'b0, 32'h0bad_000a, 32'h0);
    set_entry(3, 1, `KIND_REG,    5'd11, 1'b0, 1'b0, 32'h0bad_000b, 32'h0);
    set_entry(3, 2, `KIND_BRANCH, 5'd0,  1'b0, 1'b1, 32'h0,         32'h0000_1a40);
    set_entry(3, 3, `KIND_REG,    5'd12, 1'b0, 1'b0, 32'h0bad_000c, 32'h0);
    set_entry(3, 4, `KIND_STORE,  5'd0,  1'b0, 1'b0, 32'h0,         32'h0);
    // restart at tag zero with rdy dropping out now and then
    set_row(4, 3, 1'b1, 16'h00b6, 64'h102);
    set_entry(4, 0, `KIND_REG,    5'd20, 1'b0, 1'b0, 32'h7000_0014, 32'h0);
    set_entry(4, 1, `KIND_BRANCH, 5'd0,  1'b1, 1'b1, 32'h0,         32'h0000_0400);
    set_entry(4, 2, `KIND_REG,    5'd21, 1'b0, 1'b0, 32'h7000_0015, 32'h0);
endtask

`endif

/* testbench/tb_rob.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module tb_rob;

    import rob_pkg::*;

    localparam int NUM_ROWS   = 5;
    localparam int MAX_CYCLES = 64 * NUM_ROWS + 8;

    typedef struct packed {
        kind_t    kind;
        reg_idx_t rd;
        logic     pred;
        logic     actual;
        word_t    data;
        addr_t    target;
    } vec_entry_t;

    // one retire as seen on the ports
    // a flush carries redirect_pc in data
    typedef struct packed {
        kind_t    kind;
        rob_tag_t tag;
        reg_idx_t rd;
        word_t    data;
    } retire_t;

    logic        clk, rst, rdy, dp_valid, ex_valid, slb_valid;
    dispatch_t   dp_info;
    ex_result_t  ex_result;
    slb_result_t slb_result;
    rob_tag_t    dp_tag, store_commit_tag;
    logic        full, rf_wr_valid, store_commit_valid, flush;
    rf_write_t   rf_wr;
    addr_t       redirect_pc;

    int          row_n     [NUM_ROWS];
    logic        row_loads [NUM_ROWS];
    logic [15:0] row_gap   [NUM_ROWS];     // rdy low in completion cycle c when bit c set
    logic [63:0] row_order [NUM_ROWS];
    vec_entry_t  row_ent   [NUM_ROWS][`ROB_DEPTH];

    retire_t     seen[$];
    retire_t     expect_q[$];
    logic [31:0] lfsr = 32'h89fd;
    int          errors = 0;
    int          rows_passed = 0;
    int          cycles = 0;
    logic        rdy_last = 1'b1;
    logic        watch_full = 1'b0;
    rob_tag_t    tag_seen;
    logic        full_seen;
    rob_tag_t    next_tag = '0;

    rob_top DUT (.*);

    `include "tb_rob_vectors.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, retire sequence never finished", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
    endfunction

    function automatic rob_tag_t tag_of(rob_tag_t base, int i);
        return rob_tag_t'(int'(base) + i);
    endfunction

    task automatic compare_value(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("error %s: got %0h, expected %0h", name, got, exp);
            errors++;
        end
    endtask

    // samples outputs mid-cycle and returns on the next rising edge
    task automatic next_cycle();
        retire_t ev;
        int      pulses;
        @(negedge clk);
        pulses = int'(rf_wr_valid) + int'(store_commit_valid) + int'(flush);
        ev = '0;
        if (rf_wr_valid) begin
            ev.kind = `KIND_REG;
            ev.tag  = rf_wr.tag;
            ev.rd   = rf_wr.rd;
            ev.data = rf_wr.data;
        end else if (store_commit_valid) begin
            ev.kind = `KIND_STORE;
            ev.tag  = store_commit_tag;
        end else if (flush) begin
            ev.kind = `KIND_BRANCH;
            ev.data = redirect_pc;
        end
        if (pulses > 1) begin
            $display("more than one retire pulse in the same cycle");
            errors++;
        end
        if (pulses > 0 && !rdy_last) begin
            $display("retire pulse after a cycle with rdy low");
            errors++;
        end
        if (pulses > 0) begin
            seen.push_back(ev);
            if (watch_full) begin
                compare_value("full", 64'(full), 64'd0);   // first retire frees a slot
                watch_full = 1'b0;
            end
        end
        tag_seen  = dp_tag;
        full_seen = full;
        rdy_last  = rdy;
        @(posedge clk);
    endtask

    // in order until the first mispredicted branch
    task automatic build_expected(int r, rob_tag_t base, output logic flushed);
        retire_t    ev;
        vec_entry_t e;
        int         i;
        expect_q.delete();
        flushed = 1'b0;
        for (i = 0; i < row_n[r] && !flushed; i++) begin
            e       = row_ent[r][i];
            ev      = '0;
            ev.kind = e.kind;
            if (e.kind == `KIND_REG) begin
                ev.tag  = tag_of(base, i);
                ev.rd   = e.rd;
                ev.data = e.data;
                expect_q.push_back(ev);
            end else if (e.kind == `KIND_STORE) begin
                ev.tag = tag_of(base, i);
                expect_q.push_back(ev);
            end else if (e.pred != e.actual) begin
                ev.data = e.target;
                expect_q.push_back(ev);
                flushed = 1'b1;
            end
        end
    endtask

    task automatic drive_completion(int r, int i, rob_tag_t base);
        vec_entry_t e;
        logic       via_slb;
        e       = row_ent[r][i];
        via_slb = (e.kind == `KIND_REG) && row_loads[r];
        if (e.kind == `KIND_REG && !row_loads[r]) begin
            lfsr    = lfsr_next(lfsr);
            via_slb = lfsr[0];
        end
        if (via_slb) begin
            slb_valid  <= 1'b1;
            slb_result <= {tag_of(base, i), e.data};
        end else begin
            ex_valid  <= 1'b1;
            ex_result <= {tag_of(base, i), e.data, e.actual, e.target};
        end
    endtask

    task automatic run_row(int r);
        int       i;
        int       k;
        int       c;
        int       errs_before;
        logic     low;
        logic     flushed;
        rob_tag_t base;
        base        = next_tag;
        errs_before = errors;
        build_expected(r, base, flushed);
        seen.delete();
        for (i = 0; i < row_n[r]; i++) begin
            dp_valid <= 1'b1;
            dp_info  <= {row_ent[r][i].kind, row_ent[r][i].rd, row_ent[r][i].pred};
            next_cycle();
            compare_value("dp_tag", 64'(tag_seen), 64'(tag_of(base, i)));
        end
        if (row_n[r] == `ROB_DEPTH) begin
            dp_info <= '0;      // one request too many
            next_cycle();
            compare_value("full", 64'(full_seen), 64'd1);
            dp_valid <= 1'b0;
            next_cycle();
            compare_value("full", 64'(full_seen), 64'd1);
            compare_value("dp_tag", 64'(tag_seen), 64'(base));
            watch_full = 1'b1;
        end
        dp_valid <= 1'b0;
        k = 0;
        c = 0;
        while (k < row_n[r] || c < 16) begin
            low       = (c < 16) && row_gap[r][c[3:0]];
            rdy       <= !low;
            dp_valid  <= low;   // frozen so never accepted
            ex_valid  <= 1'b0;
            slb_valid <= 1'b0;
            if (k < row_n[r]) begin
                drive_completion(r, int'(row_order[r][4*k +: 4]), base);
                if (!low)
                    k++;
            end
            next_cycle();
            c++;
        end
        rdy       <= 1'b1;
        dp_valid  <= 1'b0;
        ex_valid  <= 1'b0;
        slb_valid <= 1'b0;
        c = 0;
        while (seen.size() < expect_q.size() && c < 32) begin
            next_cycle();
            c++;
        end
        repeat (4) next_cycle();    // room for a stray late pulse
        compare_value("retire count", 64'(seen.size()), 64'(expect_q.size()));
        for (i = 0; i < expect_q.size() && i < seen.size(); i++) begin
            compare_value("retire kind", 64'(seen[i].kind), 64'(expect_q[i].kind));
            compare_value("retire tag", 64'(seen[i].tag), 64'(expect_q[i].tag));
            compare_value("rf_wr.rd", 64'(seen[i].rd), 64'(expect_q[i].rd));
            compare_value("retire data", 64'(seen[i].data), 64'(expect_q[i].data));
        end
        if (flushed)
            next_tag = '0;
        else
            next_tag = tag_of(base, row_n[r]);
        compare_value("dp_tag", 64'(tag_seen), 64'(next_tag));
        if (errors == errs_before)
            rows_passed++;
        $display("row %0d: %0d retires, %0d errors", r, seen.size(), errors - errs_before);
    endtask

    initial begin
        int r;
        rst        = 1'b1;
        rdy        = 1'b1;
        dp_valid   = 1'b0;
        dp_info    = '0;
        ex_valid   = 1'b0;
        ex_result  = '0;
        slb_valid  = 1'b0;
        slb_result = '0;
        load_rows();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        next_cycle();
        compare_value("full", 64'(full_seen), 64'd0);
        compare_value("dp_tag", 64'(tag_seen), 64'd0);
        compare_value("retire pulses", 64'(seen.size()), 64'd0);
        $display("reset: %0d errors", errors);
        for (r = 0; r < NUM_ROWS; r++)
            run_row(r);
        $display("%0d of %0d rows passed, %0d errors", rows_passed, NUM_ROWS, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* src/rob_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_top (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  rdy,
    input  wire logic                  dp_valid,
    input  wire rob_pkg::dispatch_t    dp_info,
    output rob_pkg::rob_tag_t          dp_tag,
    output logic                       full,
    input  wire logic                  ex_valid,
    input  wire rob_pkg::ex_result_t   ex_result,
    input  wire logic                  slb_valid,
    input  wire rob_pkg::slb_result_t  slb_result,
    output logic                       rf_wr_valid,
    output rob_pkg::rf_write_t         rf_wr,
    output logic                       store_commit_valid,
    output rob_pkg::rob_tag_t          store_commit_tag,
    output logic                       flush,
    output rob_pkg::addr_t             redirect_pc
);

    import rob_pkg::*;

    logic       dp_fire;
    logic       pop;
    logic       kill;
    rob_tag_t   head;
    rob_entry_t head_entry;

    // tail doubles as the tag handed to dispatch
    rob_alloc u_alloc (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .dp_valid (dp_valid),
        .pop      (pop),
        .kill     (kill),
        .dp_fire  (dp_fire),
        .tail     (dp_tag),
        .full     (full)
    );

    rob_table u_table (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .dp_fire    (dp_fire),
        .tail       (dp_tag),
        .dp_info    (dp_info),
        .ex_valid   (ex_valid),
        .ex_result  (ex_result),
        .slb_valid  (slb_valid),
        .slb_result (slb_result),
        .pop        (pop),
        .kill       (kill),
        .head       (head),
        .head_entry (head_entry)
    );

    rob_commit u_commit (
        .clk                (clk),
        .rst                (rst),
        .rdy                (rdy),
        .head_entry         (head_entry),
        .pop                (pop),
        .kill               (kill),
        .head               (head),
        .rf_wr_valid        (rf_wr_valid),
        .rf_wr              (rf_wr),
        .store_commit_valid (store_commit_valid),
        .store_commit_tag   (store_commit_tag),
        .flush              (flush),
        .redirect_pc        (redirect_pc)
    );

endmodule

`default_nettype wire

/* src/rob_commit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module rob_commit (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 rdy,
    input  wire rob_pkg::rob_entry_t  head_entry,
    output logic                      pop,
    output logic                      kill,
    output rob_pkg::rob_tag_t         head,
    output logic                      rf_wr_valid,
    output rob_pkg::rf_write_t        rf_wr,
    output logic                      store_commit_valid,
    output rob_pkg::rob_tag_t         store_commit_tag,
    output logic                      flush,
    output rob_pkg::addr_t            redirect_pc
);

    logic is_reg;
    logic is_store;
    logic mispredict;

    assign is_reg     = (head_entry.kind == `KIND_REG);
    assign is_store   = (head_entry.kind == `KIND_STORE);
    assign mispredict = (head_entry.kind == `KIND_BRANCH) &&
                        (head_entry.pred != head_entry.actual);

    // pop carries rdy so a frozen cycle retires nothing
    assign pop  = rdy && head_entry.valid && head_entry.done;
    assign kill = pop && mispredict;

    always_ff @(posedge clk) begin
        if (rst) begin
            head               <= '0;
            rf_wr_valid        <= 1'b0;
            store_commit_valid <= 1'b0;
            flush              <= 1'b0;
        end else begin
            rf_wr_valid        <= pop && is_reg;
            store_commit_valid <= pop && is_store;
            flush              <= kill;     // correct branches stay silent

            if (kill)
                head <= '0;
            else if (pop)
                head <= head + 1'b1;
        end
    end

    // payload only meaningful alongside a pulse
    always_ff @(posedge clk) begin
        if (pop) begin
            rf_wr.rd         <= head_entry.rd;
            rf_wr.tag        <= head;
            rf_wr.data       <= head_entry.data;
            store_commit_tag <= head;
            redirect_pc      <= head_entry.target;
        end
    end

endmodule

`default_nettype wire

/* src/rob_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module rob_table (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  rdy,
    input  wire logic                  dp_fire,
    input  wire rob_pkg::rob_tag_t     tail,
    input  wire rob_pkg::dispatch_t    dp_info,
    input  wire logic                  ex_valid,
    input  wire rob_pkg::ex_result_t   ex_result,
    input  wire logic                  slb_valid,
    input  wire rob_pkg::slb_result_t  slb_result,
    input  wire logic                  pop,
    input  wire logic                  kill,
    input  wire rob_pkg::rob_tag_t     head,
    output rob_pkg::rob_entry_t        head_entry
);

    import rob_pkg::*;

    logic [`ROB_DEPTH-1:0] valid_q;
    logic [`ROB_DEPTH-1:0] done_q;

    kind_t    kind_q   [`ROB_DEPTH];
    reg_idx_t rd_q     [`ROB_DEPTH];
    word_t    data_q   [`ROB_DEPTH];
    logic     pred_q   [`ROB_DEPTH];
    logic     actual_q [`ROB_DEPTH];
    addr_t    target_q [`ROB_DEPTH];

    logic ex_hit;
    logic slb_hit;

    // stale tags from before a flush are dropped here
    assign ex_hit  = ex_valid && valid_q[ex_result.tag];
    assign slb_hit = slb_valid && valid_q[slb_result.tag];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            done_q  <= '0;
        end else if (rdy) begin
            if (kill) begin
                valid_q <= '0;
                done_q  <= '0;
            end else begin
                if (dp_fire) begin
                    valid_q[tail] <= 1'b1;
                    done_q[tail]  <= 1'b0;
                end
                if (ex_hit)
                    done_q[ex_result.tag] <= 1'b1;
                if (slb_hit)
                    done_q[slb_result.tag] <= 1'b1;
                // retire last so it wins over a late strobe on the head
                if (pop) begin
                    valid_q[head] <= 1'b0;
                    done_q[head]  <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (dp_fire) begin
                kind_q[tail] <= dp_info.kind;
                rd_q[tail]   <= dp_info.rd;
                pred_q[tail] <= dp_info.pred;
            end
            if (ex_hit) begin
                data_q[ex_result.tag]   <= ex_result.data;
                actual_q[ex_result.tag] <= ex_result.taken;
                target_q[ex_result.tag] <= ex_result.target;
            end
            if (slb_hit)
                data_q[slb_result.tag] <= slb_result.data;  // load data
        end
    end

    always_comb begin
        head_entry.valid  = valid_q[head];
        head_entry.done   = done_q[head];
        head_entry.kind   = kind_q[head];
        head_entry.rd     = rd_q[head];
        head_entry.data   = data_q[head];
        head_entry.pred   = pred_q[head];
        head_entry.actual = actual_q[head];
        head_entry.target = target_q[head];
    end

endmodule

`default_nettype wire

/* src/rob_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module rob_alloc (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        rdy,
    input  wire logic        dp_valid,
    input  wire logic        pop,
    input  wire logic        kill,
    output logic             dp_fire,
    output rob_pkg::rob_tag_t tail,
    output logic             full
);

    // one extra bit so 16 live entries is distinguishable from none
    logic [`ROB_TAG_W:0] count;

    assign full    = (count == `ROB_DEPTH);
    assign dp_fire = dp_valid && rdy && !full && !kill;

    always_ff @(posedge clk) begin
        if (rst) begin
            tail  <= '0;
            count <= '0;
        end else if (rdy) begin
            if (kill) begin
                // flush empties the buffer and restarts tags at zero
                tail  <= '0;
                count <= '0;
            end else begin
                if (dp_fire)
                    tail <= tail + 1'b1;    // wraps at depth

                case ({dp_fire, pop})
                    2'b10: begin
                        count <= count + 1'b1;
                    end
                    2'b01: begin
                        count <= count - 1'b1;
                    end
                    default: begin
                        count <= count;     // both or neither
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* src/rob_pkg.sv */
`default_nettype none

`include "rob_params.svh"

package rob_pkg;

    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;
    typedef logic [`XLEN-1:0]      word_t;
    typedef logic [`ADDR_W-1:0]    addr_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`KIND_W-1:0]    kind_t;

    // what dispatch knows about an instruction
    typedef struct packed {
        kind_t    kind;
        reg_idx_t rd;
        logic     pred;     // predicted taken
    } dispatch_t;

    typedef struct packed {
        rob_tag_t tag;
        word_t    data;
        logic     taken;    // actual branch outcome
        addr_t    target;
    } ex_result_t;

    typedef struct packed {
        rob_tag_t tag;
        word_t    data;
    } slb_result_t;

    typedef struct packed {
        reg_idx_t rd;
        rob_tag_t tag;
        word_t    data;
    } rf_write_t;

    // head entry as seen by commit
    typedef struct packed {
        logic     valid;
        logic     done;
        kind_t    kind;
        reg_idx_t rd;
        word_t    data;
        logic     pred;
        logic     actual;
        addr_t    target;
    } rob_entry_t;

endpackage

`default_nettype wire

/* src/rob_params.svh */
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// buffer geometry
`define ROB_DEPTH 16
`define ROB_TAG_W 4     // tags wrap at the depth

// datapath widths
`define XLEN      32
`define ADDR_W    32
`define REG_IDX_W 5
`define KIND_W    2

// entry kinds
`define KIND_REG    2'd0    // alu or load, writes rd
`define KIND_STORE  2'd1
`define KIND_BRANCH 2'd2    // conditional branch, no rd

`endif
